// File: rtl/credits_pkg.sv
package credits_pkg;

    //////////////////////////////
    // pixel format
    //////////////////////////////
    localparam int COLW  = 4;           // bits per colour component
    localparam int RGB_W = 3 * COLW;    // r, g, b packed msb first

    //////////////////////////////
    // on-chip memories
    //////////////////////////////
    // message: 32 text rows of 32 tiles
    localparam int MSG_AW = 10;
    localparam int MSG_DW = 9;          // {pal[1:0], code[6:0]}

    // font: 128 glyphs of 8 rows, msb is the left pixel
    localparam int FONT_AW = 10;
    localparam int FONT_DW = 8;

    // host bus
    localparam int WB_AW = 11;          // msb selects the font region
    localparam int WB_DW = 16;

    //////////////////////////////
    // scroll and palette
    //////////////////////////////
    localparam int SCROLL_SPEED = 3;    // frames between steps, minus one
    localparam int FDIV_W       = $clog2(SCROLL_SPEED + 1);

    localparam logic [RGB_W-1:0] PAL0 = 12'hf00;    // red
    localparam logic [RGB_W-1:0] PAL1 = 12'h0f0;    // green
    localparam logic [RGB_W-1:0] PAL2 = 12'h33f;    // blue
    localparam logic [RGB_W-1:0] PAL3 = 12'hfff;    // white

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

    typedef enum logic {
        REG_MSG,
        REG_FONT
    } wb_region_t;

    typedef enum logic [1:0] {
        SRC_PASS,   // overlay hidden
        SRC_DIM,    // background behind the text
        SRC_CHAR    // glyph pixel set
    } pix_src_t;

endpackage

// File: rtl/credits_dpram.sv
`timescale 1ns/10ps

module credits_dpram #(
    parameter int DW = 8,
    parameter int AW = 10
) (
    input  logic          clk,
    // write side
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    // read side
    input  logic          rcen,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, advances with the pixel pipe
    always_ff @(posedge clk) begin
        if (rcen) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: rtl/credits_wb_regs.sv
`timescale 1ns/10ps

module credits_wb_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [credits_pkg::WB_AW-1:0] wb_adr,
    input  logic [credits_pkg::WB_DW-1:0] wb_dat_w,
    output logic                          wb_ack,
    output logic                          msg_we,
    output logic                          font_we,
    output logic [credits_pkg::WB_AW-2:0] waddr,
    output logic [credits_pkg::WB_DW-1:0] wdata
);
    import credits_pkg::*;

    wb_state_t  state;
    wb_region_t region;         // target of the current access
    wb_region_t adr_region;
    logic       wr;             // current access is a write
    logic       req;

    assign req        = wb_cyc && wb_stb && (state == WB_IDLE);
    assign adr_region = wb_adr[WB_AW-1] ? REG_FONT : REG_MSG;

    //////////////////////////////
    // handshake FSM
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= WB_IDLE;
            region <= REG_MSG;
            wr     <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (req) begin
                        state  <= WB_ACK;
                        region <= adr_region;
                        wr     <= wb_we;
                    end
                end
                WB_ACK:  state <= WB_IDLE;   // single cycle ack
                default: state <= WB_IDLE;
            endcase
        end
    end

    // address and data captured with the request
    always_ff @(posedge clk) begin
        if (req) begin
            waddr <= wb_adr[WB_AW-2:0];
            wdata <= wb_dat_w;
        end
    end

    assign wb_ack  = (state == WB_ACK);
    assign msg_we  = wb_ack && wr && (region == REG_MSG);
    assign font_we = wb_ack && wr && (region == REG_FONT);   // reads only get the ack

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two clocks");

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside of an active strobe");

endmodule

// File: rtl/credits_raster.sv
`timescale 1ns/10ps

module credits_raster (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       hb,          // active high
    input  logic       vb,          // active high
    input  logic       enable,
    output logic [7:0] col,
    output logic [7:0] text_row
);
    import credits_pkg::*;

    logic [7:0]        line;        // line inside the active frame
    logic [7:0]        vpos;        // scroll position
    logic [FDIV_W-1:0] fcnt;        // frame divider
    logic              hb_d;
    logic              vb_d;
    logic              en_d;
    logic              hb_rise;
    logic              vb_rise;
    logic              en_rise;

    assign hb_rise = hb && !hb_d;
    assign vb_rise = vb && !vb_d;
    assign en_rise = enable && !en_d;

    //////////////////////////////
    // column and line counters
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_d <= 1'b0;
            vb_d <= 1'b0;
            col  <= 8'd0;
            line <= 8'd0;
        end else if (pxl_cen) begin
            hb_d <= hb;
            vb_d <= vb;
            if (hb) begin
                col <= 8'd0;
            end else if (col != 8'hff) begin
                col <= col + 8'd1;          // saturates on long lines
            end
            if (vb) begin
                line <= 8'd0;
            end else if (hb_rise) begin
                line <= line + 8'd1;
            end
        end
    end

    //////////////////////////////
    // scroll
    //////////////////////////////
    // enable is sampled on every clock so a short pulse is not lost
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_d <= 1'b0;
            fcnt <= '0;
            vpos <= 8'd0;
        end else begin
            en_d <= enable;
            if (en_rise) begin
                fcnt <= '0;                 // restart from the top
                vpos <= 8'd0;
            end else if (pxl_cen && vb_rise) begin
                if (fcnt == FDIV_W'(SCROLL_SPEED)) begin
                    fcnt <= '0;
                    vpos <= vpos + 8'd1;
                end else begin
                    fcnt <= fcnt + 1'b1;
                end
            end
        end
    end

    // wraps over the 256 lines of the message
    assign text_row = line + vpos;

    a_col_sat: assert property (@(posedge clk) disable iff (rst)
        (pxl_cen && !hb && col == 8'hff) |=> (col == 8'hff))
        else $error("column counter wrapped inside the active line");

endmodule

// File: rtl/credits_tile_fetch.sv
`timescale 1ns/10ps

module credits_tile_fetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pxl_cen,
    input  logic [7:0]                      col,
    input  logic [7:0]                      text_row,
    input  logic [credits_pkg::MSG_DW-1:0]  msg_q,
    input  logic [credits_pkg::FONT_DW-1:0] font_q,
    output logic [credits_pkg::MSG_AW-1:0]  msg_addr,
    output logic [credits_pkg::FONT_AW-1:0] font_addr,
    output logic                            char_on,
    output logic [1:0]                      char_pal
);
    import credits_pkg::*;

    logic [2:0] s1_bit;     // pixel inside the tile
    logic [2:0] s1_row;     // row inside the glyph
    logic [2:0] s2_bit;
    logic [1:0] s2_pal;

    //////////////////////////////
    // stage 1: message lookup
    //////////////////////////////
    assign msg_addr = {text_row[7:3], col[7:3]};    // tile row, tile column

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_bit <= 3'd0;
            s1_row <= 3'd0;
        end else if (pxl_cen) begin
            s1_bit <= col[2:0];
            s1_row <= text_row[2:0];
        end
    end

    //////////////////////////////
    // stage 2: font lookup
    //////////////////////////////
    // msg_q holds the tile word for the pixel in s1
    assign font_addr = {msg_q[6:0], s1_row};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_bit <= 3'd0;
            s2_pal <= 2'd0;
        end else if (pxl_cen) begin
            s2_bit <= s1_bit;
            s2_pal <= msg_q[MSG_DW-1 -: 2];
        end
    end

    //////////////////////////////
    // stage 3: glyph bit
    //////////////////////////////
    // font_q is the glyph row for the pixel in s2,
    // registered by the mixer together with the delayed image
    assign char_on  = font_q[3'd7 - s2_bit];   // msb is the leftmost pixel
    assign char_pal = s2_pal;

endmodule

// File: rtl/credits_mixer.sv
`timescale 1ns/10ps

module credits_mixer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          hb_raw,
    input  logic                          vb_raw,
    input  logic [credits_pkg::RGB_W-1:0] rgb_in,
    input  logic                          enable,
    input  logic                          toggle,
    input  logic                          char_on,
    input  logic [1:0]                    char_pal,
    output logic                          hb_out,
    output logic                          vb_out,
    output logic [credits_pkg::RGB_W-1:0] rgb_out
);
    import credits_pkg::*;

    logic             show;
    logic             en_d;
    logic             tg_d;
    logic [RGB_W-1:0] rgb_d1;
    logic [RGB_W-1:0] rgb_d2;
    logic [RGB_W-1:0] dim;
    logic [RGB_W-1:0] pal_rgb;
    logic [1:0]       hb_dly;
    logic [1:0]       vb_dly;
    pix_src_t         src;

    //////////////////////////////
    // show control
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            show <= 1'b0;
            en_d <= 1'b0;
            tg_d <= 1'b0;
        end else begin
            en_d <= enable;
            tg_d <= toggle;
            if (!enable) begin
                show <= 1'b0;
            end else if (!en_d) begin
                show <= 1'b1;               // fresh enable always shows
            end else if (toggle && !tg_d) begin
                show <= ~show;
            end
        end
    end

    //////////////////////////////
    // image delay and colour pick
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_d1 <= rgb_in;
            rgb_d2 <= rgb_d1;
        end
    end

    // half intensity per component
    assign dim = {1'b0, rgb_d2[RGB_W-1 -: COLW-1],
                  1'b0, rgb_d2[2*COLW-1 -: COLW-1],
                  1'b0, rgb_d2[COLW-1 -: COLW-1]};

    always_comb begin
        case (char_pal)
            2'd0:    pal_rgb = PAL0;
            2'd1:    pal_rgb = PAL1;
            2'd2:    pal_rgb = PAL2;
            default: pal_rgb = PAL3;
        endcase
    end

    always_comb begin
        if (!show) begin
            src = SRC_PASS;
        end else if (char_on) begin
            src = SRC_CHAR;
        end else begin
            src = SRC_DIM;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_dly  <= 2'd0;
            vb_dly  <= 2'd0;
            hb_out  <= 1'b0;
            vb_out  <= 1'b0;
            rgb_out <= '0;
        end else if (pxl_cen) begin
            {hb_out, hb_dly} <= {hb_dly, hb_raw};   // raw pins, polarity kept
            {vb_out, vb_dly} <= {vb_dly, vb_raw};
            case (src)
                SRC_CHAR: rgb_out <= pal_rgb;
                SRC_DIM:  rgb_out <= dim;
                default:  rgb_out <= rgb_d2;
            endcase
        end
    end

endmodule

// File: rtl/credits_overlay.sv
`timescale 1ns/10ps

module credits_overlay #(
    parameter bit BLKPOL = 1'b1     // 1: blanking pins are active high
) (
    input  logic                          clk,
    input  logic                          rst,
    // incoming video
    input  logic                          pxl_cen,
    input  logic                          hb,
    input  logic                          vb,
    input  logic [credits_pkg::RGB_W-1:0] rgb_in,
    input  logic                          enable,
    input  logic                          toggle,
    // host bus
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [credits_pkg::WB_AW-1:0] wb_adr,
    input  logic [credits_pkg::WB_DW-1:0] wb_dat_w,
    output logic                          wb_ack,
    // outgoing video
    output logic                          hb_out,
    output logic                          vb_out,
    output logic [credits_pkg::RGB_W-1:0] rgb_out
);
    import credits_pkg::*;

    logic               hb_a;       // active high blanking
    logic               vb_a;
    logic               msg_we;
    logic               font_we;
    logic [WB_AW-2:0]   waddr;
    logic [WB_DW-1:0]   wdata;
    logic [MSG_AW-1:0]  msg_addr;
    logic [MSG_DW-1:0]  msg_q;
    logic [FONT_AW-1:0] font_addr;
    logic [FONT_DW-1:0] font_q;
    logic [7:0]         col;
    logic [7:0]         text_row;
    logic               char_on;
    logic [1:0]         char_pal;

    assign hb_a = BLKPOL ? hb : ~hb;
    assign vb_a = BLKPOL ? vb : ~vb;

    credits_wb_regs u_regs (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
        .msg_we(msg_we), .font_we(font_we), .waddr(waddr), .wdata(wdata)
    );

    credits_dpram #(.DW(MSG_DW), .AW(MSG_AW)) u_msg (
        .clk(clk), .we(msg_we), .waddr(waddr), .wdata(wdata[MSG_DW-1:0]),
        .rcen(pxl_cen), .raddr(msg_addr), .rdata(msg_q)
    );

    credits_dpram #(.DW(FONT_DW), .AW(FONT_AW)) u_font (
        .clk(clk), .we(font_we), .waddr(waddr), .wdata(wdata[FONT_DW-1:0]),
        .rcen(pxl_cen), .raddr(font_addr), .rdata(font_q)
    );

    credits_raster u_raster (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb_a), .vb(vb_a),
        .enable(enable), .col(col), .text_row(text_row)
    );

    credits_tile_fetch u_fetch (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .col(col), .text_row(text_row),
        .msg_q(msg_q), .font_q(font_q), .msg_addr(msg_addr), .font_addr(font_addr),
        .char_on(char_on), .char_pal(char_pal)
    );

    credits_mixer u_mixer (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb_raw(hb), .vb_raw(vb),
        .rgb_in(rgb_in), .enable(enable), .toggle(toggle),
        .char_on(char_on), .char_pal(char_pal),
        .hb_out(hb_out), .vb_out(vb_out), .rgb_out(rgb_out)
    );

endmodule

// File: tests/credits_tb.sv
`timescale 1ns/10ps

module credits_tb;
    import credits_pkg::*;

    localparam int ACT_PIX   = 40;
    localparam int BLK_PIX   = 8;
    localparam int ACT_LINES = 12;
    localparam int BLK_LINES = 3;     // vblank comes first in each frame
    localparam int N_STEPS   = 6;

    logic             clk;
    logic             rst;
    logic             pxl_cen;
    logic             hb;
    logic             vb;
    logic [RGB_W-1:0] rgb_in;
    logic             enable;
    logic             toggle;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [WB_AW-1:0] wb_adr;
    logic [WB_DW-1:0] wb_dat_w;
    logic             wb_ack;
    logic             hb_out;
    logic             vb_out;
    logic [RGB_W-1:0] rgb_out;

    // reference model state
    logic [MSG_DW-1:0]  msg_ref  [0:(1<<MSG_AW)-1];
    logic [FONT_DW-1:0] font_ref [0:(1<<FONT_AW)-1];
    logic [7:0]         vpos_ref;
    int                 fdiv_ref;
    logic               show_ref;
    logic               en_prev;

    logic [RGB_W-1:0] exp_rgb [$];
    logic             exp_hb  [$];
    logic             exp_vb  [$];
    logic             exp_act [$];     // rgb only checked on active pixels
    int               pushed  = 0;
    int               checked = 0;
    int               ticks   = 0;
    integer           seed;

    // frames, enable level, one toggle pulse
    int   step_frames [N_STEPS] = '{2, 9, 1, 1, 1, 5};
    logic step_en     [N_STEPS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    logic step_tog    [N_STEPS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};

    credits_overlay #(.BLKPOL(1'b1)) DUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .hb(hb), .vb(vb), .rgb_in(rgb_in),
        .enable(enable), .toggle(toggle),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_ack(wb_ack),
        .hb_out(hb_out), .vb_out(vb_out), .rgb_out(rgb_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic fail_run(input string what);
        $display("%s (time %0t)", what, $time);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compare_rgb(input string name, input logic [RGB_W-1:0] got,
                               input logic [RGB_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_blank(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compare_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t wb_ack got=%b expected=%b", $time, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // bus and video drivers
    //////////////////////////////
    task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                              input logic [WB_DW-1:0] dat);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        while (!wb_ack) begin
            if (n == 20)
                fail_run("no wb_ack within 20 clocks of the strobe");
            @(posedge clk);
            #1;
            n++;
        end
        if (n != 1)
            fail_run("wb_ack did not follow the strobe after exactly one clock");
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        compare_ack(wb_ack, 1'b0);      // one clock wide
        if (we && adr[WB_AW-1])
            font_ref[adr[9:0]] = dat[FONT_DW-1:0];
        else if (we)
            msg_ref[adr[9:0]] = dat[MSG_DW-1:0];
    endtask

    // expected colour of an active pixel while the overlay is shown
    function automatic logic [RGB_W-1:0] overlay_pixel(input int c, input int line,
                                                       input logic [RGB_W-1:0] rgb);
        logic [7:0]         r;
        logic [MSG_DW-1:0]  tile;
        logic [FONT_DW-1:0] glyph;
        r     = line + vpos_ref;            // wraps at 256
        tile  = msg_ref[(r / 8) * 32 + c / 8];
        glyph = font_ref[tile[6:0] * 8 + r % 8];
        if (glyph[7 - c % 8]) begin
            case (tile[8:7])
                2'd0:    return PAL0;
                2'd1:    return PAL1;
                2'd2:    return PAL2;
                default: return PAL3;
            endcase
        end
        return (rgb >> 1) & 12'h777;        // each component halved
    endfunction

    task automatic drive_pixel(input logic h, input logic v, input int c, input int line);
        logic [RGB_W-1:0] px;
        logic             active;
        @(posedge clk);
        #1;
        px      = $random(seed);
        active  = !h && !v;
        pxl_cen = 1'b1;
        hb      = h;
        vb      = v;
        rgb_in  = px;
        exp_hb.push_back(h);
        exp_vb.push_back(v);
        exp_act.push_back(active);
        exp_rgb.push_back((active && show_ref) ? overlay_pixel(c, line, px) : px);
        pushed++;
        @(posedge clk);
        #1;
        pxl_cen = 1'b0;
    endtask

    task automatic drive_frame(input logic en, input logic tog);
        for (int l = 0; l < BLK_LINES + ACT_LINES; l++) begin
            for (int p = 0; p < ACT_PIX + BLK_PIX; p++) begin
                if (l == 0 && p == 0) begin
                    // vblank start steps the frame divider
                    if (fdiv_ref == SCROLL_SPEED) begin
                        fdiv_ref = 0;
                        vpos_ref = vpos_ref + 8'd1;
                    end else begin
                        fdiv_ref++;
                    end
                end
                if (l == 1 && p == 0) begin
                    enable = en;
                    if (en && !en_prev) begin
                        vpos_ref = 8'd0;     // scroll restarts
                        fdiv_ref = 0;
                        show_ref = 1'b1;
                    end else if (!en) begin
                        show_ref = 1'b0;
                    end
                    en_prev = en;
                end
                if (l == 2 && p == 0 && tog) begin
                    toggle = 1'b1;
                    if (en)
                        show_ref = !show_ref;
                end
                if (l == 2 && p == 1)
                    toggle = 1'b0;
                drive_pixel(p >= ACT_PIX, l < BLK_LINES, p, l - BLK_LINES);
            end
        end
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////
    initial begin
        forever begin
            @(posedge clk);
            if (pxl_cen) begin
                #2;
                ticks++;
                if (ticks > 2) begin        // pipe filled
                    if (exp_rgb.size() == 0)
                        fail_run("output seen with no expected pixel left");
                    compare_blank("hb_out", hb_out, exp_hb.pop_front());
                    compare_blank("vb_out", vb_out, exp_vb.pop_front());
                    if (exp_act.pop_front())
                        compare_rgb("rgb_out", rgb_out, exp_rgb.pop_front());
                    else
                        void'(exp_rgb.pop_front());
                    checked++;
                end
            end
        end
    end

    initial begin : stimulus
        int               n;
        int               total;
        logic [WB_DW-1:0] d;
        seed     = 32'h3281_e171;
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        hb       = 1'b0;
        vb       = 1'b0;
        rgb_in   = '0;
        enable   = 1'b0;
        toggle   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        vpos_ref = 8'd0;
        fdiv_ref = 0;
        show_ref = 1'b0;
        en_prev  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_ack(wb_ack, 1'b0);

        for (int a = 0; a < (1 << MSG_AW); a++) begin
            d = $random(seed);
            bus_access(1'b1, {1'b0, a[9:0]}, d);
        end
        for (int a = 0; a < (1 << FONT_AW); a++) begin
            d = $random(seed);
            bus_access(1'b1, {1'b1, a[9:0]}, d);
        end
        bus_access(1'b0, 11'h000, 16'h01ff);  // read, ack only

        for (int s = 0; s < N_STEPS; s++) begin
            for (int f = 0; f < step_frames[s]; f++)
                drive_frame(step_en[s], step_tog[s] && (f == 0));
        end

        // blank pixels push the last frame out of the pipe
        total = pushed;
        n = 0;
        while (checked < total) begin
            if (n == 20)
                fail_run("video output stalled before the last pixel");
            drive_pixel(1'b1, 1'b1, 0, 0);
            n++;
        end

        if (checked >= total) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

endmodule

// File: flist.f
rtl/credits_pkg.sv
rtl/credits_dpram.sv
rtl/credits_wb_regs.sv
rtl/credits_raster.sv
rtl/credits_tile_fetch.sv
rtl/credits_mixer.sv
rtl/credits_overlay.sv
tests/credits_tb.sv
